// ==== hw/disp_pkg.sv ====
package disp_pkg;

	////////////////////////////////////////
	// Bus and payload widths
	////////////////////////////////////////

	localparam int addr_w = 8;
	localparam int data_w = 32;

	// One digit, segments a-g plus the dot position
	localparam int seg_w = 8;

	localparam int led_w = 16;
	localparam int sw_w = 16;

	////////////////////////////////////////
	// Device address map
	////////////////////////////////////////

	// Upper address nibble picks the device, so a region is sixteen bytes
	localparam int region_w = 4;

	localparam logic [addr_w-1:0] dev_tube_base = 8'h40;
	localparam logic [addr_w-1:0] dev_io_base = 8'h50;

	// Word offset inside a region, address bits 3:2
	localparam int off_w = 2;

	// Display device
	localparam logic [off_w-1:0] reg_digits = 2'd0;
	localparam logic [off_w-1:0] reg_single = 2'd1;

	// I/O device
	localparam logic [off_w-1:0] reg_led = 2'd0;
	localparam logic [off_w-1:0] reg_switch = 2'd1;

	////////////////////////////////////////
	// Display scan
	////////////////////////////////////////

	// 1 ms per digit at 125 MHz
	localparam int scan_divide_default = 125000;

endpackage

// ==== hw/periph_bridge.sv ====
`timescale 1ns/1ps

module periph_bridge
(
	input  logic [disp_pkg::addr_w-1:0] addr,
	input  logic                        we,
	input  logic [disp_pkg::data_w-1:0] tube_rdata,
	input  logic [disp_pkg::data_w-1:0] io_rdata,
	output logic                        tube_we,
	output logic                        io_we,
	output logic [disp_pkg::off_w-1:0]  reg_off,
	output logic [disp_pkg::data_w-1:0] rdata
);
	import disp_pkg::*;

	logic [region_w-1:0] region;
	logic                tube_hit;
	logic                io_hit;

	////////////////////////////////////////
	// Region decode
	////////////////////////////////////////

	// Upper nibble of the byte address
	assign region = addr[addr_w-1 -: region_w];

	assign tube_hit = (region == dev_tube_base[addr_w-1 -: region_w]);
	assign io_hit = (region == dev_io_base[addr_w-1 -: region_w]);

	// Word offset, the byte lane bits are dropped
	assign reg_off = addr[off_w+1:2];

	////////////////////////////////////////
	// Write strobes
	////////////////////////////////////////

	// At most one device sees the strobe
	assign tube_we = we & tube_hit;
	assign io_we = we & io_hit;

	////////////////////////////////////////
	// Read data
	////////////////////////////////////////

	always_comb
	begin
		if (tube_hit)
		begin
			rdata = tube_rdata;
		end
		else if (io_hit)
		begin
			rdata = io_rdata;
		end
		else
		begin
			// Unmapped region
			rdata = '0;
		end
	end

endmodule

// ==== hw/tube_regs.sv ====
`timescale 1ns/1ps

module tube_regs
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        we,
	input  logic [disp_pkg::off_w-1:0]  reg_off,
	input  logic [disp_pkg::data_w-1:0] wdata,
	output logic [disp_pkg::data_w-1:0] rdata,
	output logic [disp_pkg::data_w-1:0] digits_word,
	output logic [disp_pkg::data_w-1:0] single_word
);
	import disp_pkg::*;

	////////////////////////////////////////
	// Display words
	////////////////////////////////////////

	// Word 0 feeds both four-digit groups, word 1 the single digit
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			digits_word <= '0;
			single_word <= '0;
		end
		else if (we)
		begin
			if (reg_off == reg_digits)
			begin
				digits_word <= wdata;
			end
			else if (reg_off == reg_single)
			begin
				single_word <= wdata;
			end
		end
	end

	////////////////////////////////////////
	// Readback
	////////////////////////////////////////

	always_comb
	begin
		case (reg_off)
			reg_digits:
			begin
				rdata = digits_word;
			end
			reg_single:
			begin
				rdata = single_word;
			end
			default:
			begin
				// Offsets 2 and 3 are not mapped
				rdata = '0;
			end
		endcase
	end

endmodule

// ==== hw/tube_scan.sv ====
`timescale 1ns/1ps

module tube_scan
#(
	parameter int scan_divide = disp_pkg::scan_divide_default
)
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic [disp_pkg::data_w-1:0] digits_word,
	input  logic [disp_pkg::data_w-1:0] single_word,
	output logic [disp_pkg::seg_w-1:0]  seg_lo,
	output logic [disp_pkg::seg_w-1:0]  seg_hi,
	output logic [disp_pkg::seg_w-1:0]  seg_single,
	output logic [3:0]                  sel_lo,
	output logic [3:0]                  sel_hi,
	output logic                        sel_single
);
	import disp_pkg::*;

	// Enough bits to hold 0 .. scan_divide-1
	localparam int cnt_w = $clog2(scan_divide);

	logic [cnt_w-1:0] count;
	logic [1:0]       idx;
	logic             tick;
	logic [3:0]       nib_lo;
	logic [3:0]       nib_hi;
	logic [3:0]       nib_single;

	////////////////////////////////////////
	// Hex to segment table
	////////////////////////////////////////

	// Active low, bit 7 held high and bits 6:0 carry a..g
	function automatic logic [seg_w-1:0] hex_to_seg(input logic [3:0] nibble);
		logic [6:0] lit;
		case (nibble)
			4'h0: lit = 7'b1111110;
			4'h1: lit = 7'b0110000;
			4'h2: lit = 7'b1101101;
			4'h3: lit = 7'b1111001;
			4'h4: lit = 7'b0110011;
			4'h5: lit = 7'b1011011;
			4'h6: lit = 7'b1011111;
			4'h7: lit = 7'b1110000;
			4'h8: lit = 7'b1111111;
			4'h9: lit = 7'b1111011;
			4'ha: lit = 7'b1110111;
			4'hb: lit = 7'b0011111;
			4'hc: lit = 7'b1001110;
			4'hd: lit = 7'b0111101;
			4'he: lit = 7'b1001111;
			default: lit = 7'b1000111;
		endcase
		return {1'b1, ~lit};
	endfunction

	////////////////////////////////////////
	// Scan divider
	////////////////////////////////////////

	assign tick = (count == cnt_w'(scan_divide - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			idx <= '0;
		end
		else if (tick)
		begin
			count <= '0;
			// Wraps after digit 3
			idx <= idx + 2'd1;
		end
		else
		begin
			count <= count + 1'b1;
		end
	end

	////////////////////////////////////////
	// Digit select and outputs
	////////////////////////////////////////

	// Low group shows nibbles 0-3, high group nibbles 4-7
	assign nib_lo = digits_word[4*idx +: 4];
	assign nib_hi = digits_word[4*idx + 16 +: 4];
	assign nib_single = single_word[3:0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			seg_lo <= '0;
			seg_hi <= '0;
			seg_single <= '0;
			sel_lo <= 4'hf;
			sel_hi <= 4'hf;
			sel_single <= 1'b1;
		end
		else if (tick)
		begin
			seg_lo <= hex_to_seg(nib_lo);
			seg_hi <= hex_to_seg(nib_hi);
			seg_single <= hex_to_seg(nib_single);
			// Both groups drive the same digit position
			sel_lo <= 4'b0001 << idx;
			sel_hi <= 4'b0001 << idx;
			sel_single <= 1'b1;
		end
	end

endmodule

// ==== hw/led_switch_dev.sv ====
`timescale 1ns/1ps

module led_switch_dev
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        we,
	input  logic [disp_pkg::off_w-1:0]  reg_off,
	input  logic [disp_pkg::data_w-1:0] wdata,
	input  logic [disp_pkg::sw_w-1:0]   switches,
	output logic [disp_pkg::data_w-1:0] rdata,
	output logic [disp_pkg::led_w-1:0]  leds
);
	import disp_pkg::*;

	logic [sw_w-1:0] sw_meta;
	logic [sw_w-1:0] sw_sync;

	////////////////////////////////////////
	// LED register
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			leds <= '0;
		end
		else if (we && reg_off == reg_led)
		begin
			// Upper half of the bus word is dropped
			leds <= wdata[led_w-1:0];
		end
	end

	////////////////////////////////////////
	// Switch synchronizer
	////////////////////////////////////////

	// Two flops, switches are asynchronous to clk
	always_ff @(posedge clk)
	begin
		sw_meta <= switches;
		sw_sync <= sw_meta;
	end

	// Readback
	always_comb
	begin
		case (reg_off)
			reg_led:
			begin
				rdata = data_w'(leds);
			end
			reg_switch:
			begin
				rdata = data_w'(sw_sync);
			end
			default:
			begin
				rdata = '0;
			end
		endcase
	end

endmodule

// ==== hw/disp_top.sv ====
`timescale 1ns/1ps

module disp_top
#(
	parameter int scan_divide = disp_pkg::scan_divide_default
)
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic [disp_pkg::addr_w-1:0] addr,
	input  logic                        we,
	input  logic [disp_pkg::data_w-1:0] wdata,
	input  logic [disp_pkg::sw_w-1:0]   switches,
	output logic [disp_pkg::data_w-1:0] rdata,
	output logic [disp_pkg::seg_w-1:0]  seg_lo,
	output logic [3:0]                  sel_lo,
	output logic [disp_pkg::seg_w-1:0]  seg_hi,
	output logic [3:0]                  sel_hi,
	output logic [disp_pkg::seg_w-1:0]  seg_single,
	output logic                        sel_single,
	output logic [disp_pkg::led_w-1:0]  leds
);
	import disp_pkg::*;

	logic              tube_we;
	logic              io_we;
	logic [off_w-1:0]  reg_off;
	logic [data_w-1:0] tube_rdata;
	logic [data_w-1:0] io_rdata;
	logic [data_w-1:0] digits_word;
	logic [data_w-1:0] single_word;

	////////////////////////////////////////
	// Bus side
	////////////////////////////////////////

	periph_bridge periph_bridge_i (
		.addr       (addr),
		.we         (we),
		.tube_rdata (tube_rdata),
		.io_rdata   (io_rdata),
		.tube_we    (tube_we),
		.io_we      (io_we),
		.reg_off    (reg_off),
		.rdata      (rdata)
	);

	tube_regs tube_regs_i (
		.clk         (clk),
		.reset       (reset),
		.we          (tube_we),
		.reg_off     (reg_off),
		.wdata       (wdata),
		.rdata       (tube_rdata),
		.digits_word (digits_word),
		.single_word (single_word)
	);

	led_switch_dev led_switch_dev_i (
		.clk      (clk),
		.reset    (reset),
		.we       (io_we),
		.reg_off  (reg_off),
		.wdata    (wdata),
		.switches (switches),
		.rdata    (io_rdata),
		.leds     (leds)
	);

	////////////////////////////////////////
	// Display side
	////////////////////////////////////////

	tube_scan #(
		.scan_divide (scan_divide)
	) tube_scan_i (
		.clk         (clk),
		.reset       (reset),
		.digits_word (digits_word),
		.single_word (single_word),
		.seg_lo      (seg_lo),
		.seg_hi      (seg_hi),
		.seg_single  (seg_single),
		.sel_lo      (sel_lo),
		.sel_hi      (sel_hi),
		.sel_single  (sel_single)
	);

endmodule

// ==== dv/disp_checker.sv ====
`timescale 1ns/1ps

module disp_checker
#(
	parameter int scan_divide = disp_pkg::scan_divide_default
)
(
	input logic                       clk,
	input logic                       reset,
	input logic [disp_pkg::seg_w-1:0] seg_lo,
	input logic [disp_pkg::seg_w-1:0] seg_hi,
	input logic [disp_pkg::seg_w-1:0] seg_single,
	input logic [3:0]                 sel_lo,
	input logic [3:0]                 sel_hi,
	input logic                       sel_single
);
	import disp_pkg::*;

	localparam int disp_w = 3 * seg_w + 9;

	logic [disp_w-1:0] disp_now;
	logic [disp_w-1:0] disp_prev;
	int unsigned       slot;

	assign disp_now = {seg_lo, seg_hi, seg_single, sel_lo, sel_hi, sel_single};

	// Slot is zero right after each scheduled update edge
	always_ff @(posedge clk)
	begin
		disp_prev <= disp_now;
		if (reset)
		begin
			slot <= 0;
		end
		else if (slot == scan_divide - 1)
		begin
			slot <= 0;
		end
		else
		begin
			slot <= slot + 1;
		end
	end

	////////////////////////////////////////
	// Display output properties
	////////////////////////////////////////

	sel_groups_match: assert property (@(posedge clk) disable iff (reset)
		sel_lo == sel_hi)
		else $error("sel_lo and sel_hi select different digits");

	sel_onehot_or_off: assert property (@(posedge clk) disable iff (reset)
		$onehot(sel_lo) || sel_lo == 4'hf)
		else $error("sel_lo is neither one-hot nor all ones");

	single_always_on: assert property (@(posedge clk) disable iff (reset)
		sel_single == 1'b1)
		else $error("sel_single dropped low");

	// Any output change must come from an update edge
	change_on_update: assert property (@(posedge clk) disable iff (reset)
		disp_now != disp_prev |-> slot == 0)
		else $error("Display outputs changed between update edges");

endmodule

bind disp_top disp_checker #(
	.scan_divide (scan_divide)
) disp_checker_i (
	.clk        (clk),
	.reset      (reset),
	.seg_lo     (seg_lo),
	.seg_hi     (seg_hi),
	.seg_single (seg_single),
	.sel_lo     (sel_lo),
	.sel_hi     (sel_hi),
	.sel_single (sel_single)
);

// ==== dv/disp_tb.sv ====
`timescale 1ns/1ps

module disp_tb;
	import disp_pkg::*;

	localparam int scan_div = 8;
	// Well above the length of all tests together
	localparam int timeout_cycles = 2000;

	// Bit n of each mask is set when hex digit n lights that segment
	localparam logic [15:0] lit_a = 16'hd7ed;
	localparam logic [15:0] lit_b = 16'h279f;
	localparam logic [15:0] lit_c = 16'h2ffb;
	localparam logic [15:0] lit_d = 16'h7b6d;
	localparam logic [15:0] lit_e = 16'hfd45;
	localparam logic [15:0] lit_f = 16'hdf71;
	localparam logic [15:0] lit_g = 16'hef7c;

	localparam logic [addr_w-1:0] digits_addr = dev_tube_base | {4'h0, reg_digits, 2'b00};
	localparam logic [addr_w-1:0] single_addr = dev_tube_base | {4'h0, reg_single, 2'b00};
	localparam logic [addr_w-1:0] led_addr = dev_io_base | {4'h0, reg_led, 2'b00};
	localparam logic [addr_w-1:0] switch_addr = dev_io_base | {4'h0, reg_switch, 2'b00};

	logic              clk;
	logic              reset;
	logic [addr_w-1:0] addr;
	logic              we;
	logic [data_w-1:0] wdata;
	logic [sw_w-1:0]   switches;
	logic [data_w-1:0] rdata;
	logic [seg_w-1:0]  seg_lo;
	logic [3:0]        sel_lo;
	logic [seg_w-1:0]  seg_hi;
	logic [3:0]        sel_hi;
	logic [seg_w-1:0]  seg_single;
	logic              sel_single;
	logic [led_w-1:0]  leds;

	integer seed;
	int     errors;
	int     cycles = 0;

	disp_top #(.scan_divide(scan_div)) disp_top_i (.*);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Active low with bit 7 always high
	function automatic logic [seg_w-1:0] expected_seg(input logic [3:0] nibble);
		logic [6:0] lit;
		lit = {lit_a[nibble], lit_b[nibble], lit_c[nibble], lit_d[nibble],
			lit_e[nibble], lit_f[nibble], lit_g[nibble]};
		return {1'b1, ~lit};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// All bus tasks start and end 1 ns after a rising edge
	task automatic bus_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
		addr = a;
		wdata = d;
		we = 1'b1;
		@(posedge clk);
		#1;
		we = 1'b0;
	endtask

	task automatic bus_read(input logic [addr_w-1:0] a, output logic [data_w-1:0] data);
		addr = a;
		we = 1'b0;
		#2;
		data = rdata;
		@(posedge clk);
		#1;
	endtask

	task automatic read_check(input string name, input logic [addr_w-1:0] a,
		input logic [data_w-1:0] expected);
		logic [data_w-1:0] data;
		bus_read(a, data);
		check_value(name, expected, data);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		we = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	// Waits for the next digit step and counts the edges
	task automatic wait_update(output int edges);
		logic [3:0] prev;
		prev = sel_lo;
		edges = 0;
		while (sel_lo == prev)
		begin
			@(posedge clk);
			#1;
			edges++;
		end
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic reset_state_test();
		check_value("seg_lo", 0, seg_lo);
		check_value("seg_hi", 0, seg_hi);
		check_value("seg_single", 0, seg_single);
		check_value("sel_lo", 4'hf, sel_lo);
		check_value("sel_hi", 4'hf, sel_hi);
		check_value("sel_single", 1, sel_single);
		check_value("leds", 0, leds);
		read_check("digits word", digits_addr, 0);
		read_check("single word", single_addr, 0);
		read_check("led word", led_addr, 0);
		read_check("switch word", switch_addr, 0);
	endtask

	task automatic register_access_test();
		bus_write(digits_addr, 32'hdead_beef);
		bus_write(single_addr, 32'h1234_5678);
		bus_write(led_addr, 32'h0000_3c5a);
		read_check("digits word", digits_addr, 32'hdead_beef);
		read_check("single word", single_addr, 32'h1234_5678);
		read_check("led word", led_addr, 32'h0000_3c5a);
		// Unmapped offsets and the read-only switch word
		bus_write(dev_tube_base | 8'h08, 32'h1111_1111);
		bus_write(dev_tube_base | 8'h0c, 32'h2222_2222);
		bus_write(switch_addr, 32'hffff_ffff);
		bus_write(dev_io_base | 8'h08, 32'h3333_3333);
		read_check("tube offset 2", dev_tube_base | 8'h08, 0);
		read_check("tube offset 3", dev_tube_base | 8'h0c, 0);
		read_check("switch word", switch_addr, 0);
		// Regions outside both devices
		bus_write(8'h00, 32'h4444_4444);
		bus_write(8'h64, 32'h5555_5555);
		bus_write(8'hf8, 32'h6666_6666);
		read_check("region 0", 8'h00, 0);
		read_check("region 6", 8'h64, 0);
		read_check("region f", 8'hf8, 0);
		read_check("digits word kept", digits_addr, 32'hdead_beef);
		read_check("single word kept", single_addr, 32'h1234_5678);
		read_check("led word kept", led_addr, 32'h0000_3c5a);
	endtask

	task automatic led_output_test();
		logic [data_w-1:0] values [3];
		values = '{32'h9876_1e2d, 32'h0000_ffff, 32'hffff_a0a0};
		for (int i = 0; i < 3; i++)
		begin
			bus_write(led_addr, values[i]);
			check_value("leds", values[i][15:0], leds);
		end
		bus_write(digits_addr, 32'h0);
		idle_cycles(2);
		check_value("leds held", 16'ha0a0, leds);
	endtask

	task automatic switch_readback_test();
		logic [sw_w-1:0] old_value;
		logic [sw_w-1:0] new_value;
		old_value = switches;
		repeat (6)
		begin
			new_value = 16'($random(seed));
			switches = new_value;
			idle_cycles(1);
			read_check("switch after one edge", switch_addr, old_value);
			read_check("switch after two edges", switch_addr, new_value);
			old_value = new_value;
		end
	endtask

	// The first gap is counted from the release of reset
	task automatic scan_period_test();
		int edges;
		apply_reset();
		for (int i = 0; i < 4; i++)
		begin
			wait_update(edges);
			check_value("edges between updates", scan_div, edges);
		end
	endtask

	task automatic scan_content_test();
		logic [data_w-1:0] digits;
		logic [3:0]        lo_nibbles [4];
		logic [3:0]        hi_nibbles [4];
		logic [3:0]        selects [4];
		int                edges;
		digits = 32'h7a5e_c3b1;
		// Digits of the word above, low group then high group
		lo_nibbles = '{4'h1, 4'hb, 4'h3, 4'hc};
		hi_nibbles = '{4'he, 4'h5, 4'ha, 4'h7};
		selects = '{4'b0001, 4'b0010, 4'b0100, 4'b1000};
		apply_reset();
		bus_write(digits_addr, digits);
		bus_write(single_addr, 32'h0000_00d6);
		for (int i = 0; i < 4; i++)
		begin
			wait_update(edges);
			check_value("sel_lo", selects[i], sel_lo);
			check_value("sel_hi", selects[i], sel_hi);
			check_value("seg_lo", expected_seg(lo_nibbles[i]), seg_lo);
			check_value("seg_hi", expected_seg(hi_nibbles[i]), seg_hi);
			check_value("seg_single", expected_seg(4'h6), seg_single);
		end
		wait_update(edges);
		check_value("sel_lo after wrap", 1, sel_lo);
		// Write lands on the next update edge, which still shows the old word
		idle_cycles(7);
		bus_write(digits_addr, 32'h0000_0000);
		check_value("sel_lo", 2, sel_lo);
		check_value("seg_lo old word", expected_seg(digits[7:4]), seg_lo);
		wait_update(edges);
		check_value("seg_lo new word", expected_seg(4'h0), seg_lo);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		addr = '0;
		we = 1'b0;
		wdata = '0;
		switches = '0;
		seed = 97895;
		errors = 0;
		apply_reset();
		reset_state_test();
		register_access_test();
		led_output_test();
		switch_readback_test();
		scan_period_test();
		scan_content_test();
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
hw/disp_pkg.sv
hw/periph_bridge.sv
hw/tube_regs.sv
hw/tube_scan.sv
hw/led_switch_dev.sv
hw/disp_top.sv
dv/disp_checker.sv
dv/disp_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module disp_tb -f verilog.f -o disp_sim

output=$(./obj_dir/disp_sim)
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation did not pass"
exit 1
